// File: common/track_pkg.sv
package track_pkg;

	////////////////////
	// widths and stream constants

	localparam int BYTE_W    = 8;
	localparam int PIX_W     = 16;
	localparam int COORD_W   = 11;
	localparam int CAM_DELAY = 4;

	// luma strictly above this counts as bright
	localparam logic [BYTE_W-1:0] Y_THRESH = 8'd200;

	// border colour
	localparam logic [PIX_W-1:0] BOX_PIX = 16'hff80;

	////////////////////
	// payloads and states

	typedef struct packed {
		logic              vsync;
		logic              href;
		logic [BYTE_W-1:0] data;
	} cam_raw_t;

	typedef struct packed {
		logic             valid;
		logic [PIX_W-1:0] data;
	} pix_out_t;

	typedef enum logic [1:0] {
		ST_IDLE       = 2'd0,
		ST_WAIT_FRAME = 2'd1,
		ST_CAPTURE    = 2'd2,
		ST_REPORT     = 2'd3
	} track_state_t;

endpackage

// File: source/sig_delay.sv
`timescale 1ns/100ps

module sig_delay import track_pkg::*; #(
	parameter type T     = cam_raw_t,
	parameter int  DELAY = CAM_DELAY
) (
	input  logic cmos_pclk_gbuf,
	input  logic rst_n,
	input  T     i_data,
	output T     o_data
);

	T dly_r [DELAY];

	// stage 0 takes the input, the rest shift down the chain
	always_ff @(posedge cmos_pclk_gbuf or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 0; i < DELAY; i++) begin
				dly_r[i] <= '0;
			end
		end else begin
			dly_r[0] <= i_data;
			for (int i = 1; i < DELAY; i++) begin
				dly_r[i] <= dly_r[i-1];
			end
		end
	end

	assign o_data = dly_r[DELAY-1];

endmodule

// File: source/pix_pack.sv
`timescale 1ns/100ps

module pix_pack import track_pkg::*; (
	input  logic              cmos_pclk_gbuf,
	input  logic              rst_n,
	input  logic              i_href,
	input  logic [BYTE_W-1:0] i_byte,
	output logic              o_pix_valid,
	output logic [PIX_W-1:0]  o_pix_data,
	output logic              o_href
);

	logic              phase_r;
	logic [BYTE_W-1:0] luma_r;

	// phase 0 expects the luma byte, phase 1 the second byte
	always_ff @(posedge cmos_pclk_gbuf or negedge rst_n) begin
		if (!rst_n) begin
			phase_r     <= 1'b0;
			o_pix_valid <= 1'b0;
			o_href      <= 1'b0;
		end else begin
			o_href      <= i_href;
			o_pix_valid <= i_href & phase_r;
			if (i_href) begin
				phase_r <= ~phase_r;
			end else begin
				phase_r <= 1'b0;
			end
		end
	end

	// byte storage
	always_ff @(posedge cmos_pclk_gbuf) begin
		if (i_href && !phase_r) begin
			luma_r <= i_byte;
		end
		if (i_href && phase_r) begin
			o_pix_data <= {luma_r, i_byte};
		end
	end

endmodule

// File: tracker/track_fsm.sv
`timescale 1ns/100ps

module track_fsm import track_pkg::*; (
	input  logic cmos_pclk_gbuf,
	input  logic rst_n,
	input  logic i_vsync,
	input  logic i_track_en,
	output logic o_frame_start,
	output logic o_capture,
	output logic o_frame_end
);

	track_state_t state_r;
	logic         vsync_d;
	logic         vs_fall;
	logic         vs_rise;

	// vsync is high in blanking, active frame sits between fall and rise
	assign vs_fall = vsync_d & ~i_vsync;
	assign vs_rise = ~vsync_d & i_vsync;

	always_ff @(posedge cmos_pclk_gbuf or negedge rst_n) begin
		if (!rst_n) begin
			state_r       <= ST_IDLE;
			vsync_d       <= 1'b0;
			o_frame_start <= 1'b0;
			o_frame_end   <= 1'b0;
		end else begin
			vsync_d       <= i_vsync;
			o_frame_start <= 1'b0;
			o_frame_end   <= 1'b0;
			case (state_r)
				ST_IDLE: begin
					if (i_track_en) begin
						state_r <= ST_WAIT_FRAME;
					end
				end
				ST_WAIT_FRAME: begin
					if (!i_track_en) begin
						state_r <= ST_IDLE;
					end else if (vs_fall) begin
						state_r       <= ST_CAPTURE;
						o_frame_start <= 1'b1;
					end
				end
				ST_CAPTURE: begin
					// frame runs to its end even if tracking is dropped
					if (vs_rise) begin
						state_r     <= ST_REPORT;
						o_frame_end <= 1'b1;
					end
				end
				ST_REPORT: begin
					state_r <= i_track_en ? ST_WAIT_FRAME : ST_IDLE;
				end
				default: begin
					state_r <= ST_IDLE;
				end
			endcase
		end
	end

	assign o_capture = (state_r == ST_CAPTURE);

endmodule

// File: tracker/pix_pos_cnt.sv
`timescale 1ns/100ps

module pix_pos_cnt import track_pkg::*; (
	input  logic               cmos_pclk_gbuf,
	input  logic               rst_n,
	input  logic               i_frame_start,
	input  logic               i_pix_valid,
	input  logic               i_href,
	output logic [COORD_W-1:0] o_col,
	output logic [COORD_W-1:0] o_row
);

	logic [COORD_W-1:0] col_cnt;
	logic [COORD_W-1:0] row_cnt;
	logic               href_d;
	logic               href_fall;

	assign href_fall = href_d & ~i_href;

	always_ff @(posedge cmos_pclk_gbuf or negedge rst_n) begin
		if (!rst_n) begin
			href_d  <= 1'b0;
			col_cnt <= '0;
			row_cnt <= '0;
			o_col   <= '0;
			o_row   <= '0;
		end else begin
			href_d <= i_href;
			// position of the current pixel, one stage behind
			o_col  <= col_cnt;
			o_row  <= row_cnt;
			if (href_fall || i_frame_start) begin
				col_cnt <= '0;
			end else if (i_pix_valid) begin
				col_cnt <= col_cnt + 1'b1;
			end
			if (i_frame_start) begin
				row_cnt <= '0;
			end else if (href_fall) begin
				row_cnt <= row_cnt + 1'b1;
			end
		end
	end

endmodule

// File: tracker/box_track.sv
`timescale 1ns/100ps

module box_track import track_pkg::*; (
	input  logic               cmos_pclk_gbuf,
	input  logic               rst_n,
	input  logic               i_frame_start,
	input  logic               i_capture,
	input  logic               i_frame_end,
	input  logic               i_pix_valid,
	input  logic [PIX_W-1:0]   i_pix_data,
	input  logic [COORD_W-1:0] i_col,
	input  logic [COORD_W-1:0] i_row,
	output logic [COORD_W-1:0] o_col_min,
	output logic [COORD_W-1:0] o_col_max,
	output logic [COORD_W-1:0] o_row_min,
	output logic [COORD_W-1:0] o_row_max,
	output logic               o_box_valid,
	output logic               o_track_done
);

	logic               bright_q;
	logic               hit_r;
	logic               done_q;
	logic [COORD_W-1:0] col_min_r;
	logic [COORD_W-1:0] col_max_r;
	logic [COORD_W-1:0] row_min_r;
	logic [COORD_W-1:0] row_max_r;

	////////////////////
	// control and results

	always_ff @(posedge cmos_pclk_gbuf or negedge rst_n) begin
		if (!rst_n) begin
			bright_q     <= 1'b0;
			hit_r        <= 1'b0;
			done_q       <= 1'b0;
			o_track_done <= 1'b0;
			o_box_valid  <= 1'b0;
			o_col_min    <= '0;
			o_col_max    <= '0;
			o_row_min    <= '0;
			o_row_max    <= '0;
		end else begin
			// registered so it lines up with the counter position
			bright_q <= i_capture & i_pix_valid & (i_pix_data[PIX_W-1 -: BYTE_W] > Y_THRESH);
			if (i_frame_start) begin
				hit_r <= 1'b0;
			end else if (bright_q) begin
				hit_r <= 1'b1;
			end
			if (i_frame_end) begin
				o_col_min   <= col_min_r;
				o_col_max   <= col_max_r;
				o_row_min   <= row_min_r;
				o_row_max   <= row_max_r;
				o_box_valid <= hit_r;
			end
			done_q       <= i_frame_end;
			o_track_done <= done_q;
		end
	end

	////////////////////
	// running extents

	always_ff @(posedge cmos_pclk_gbuf) begin
		if (i_frame_start) begin
			col_min_r <= '1;
			col_max_r <= '0;
			row_min_r <= '1;
			row_max_r <= '0;
		end else if (bright_q) begin
			if (i_col < col_min_r) col_min_r <= i_col;
			if (i_col > col_max_r) col_max_r <= i_col;
			if (i_row < row_min_r) row_min_r <= i_row;
			if (i_row > row_max_r) row_max_r <= i_row;
		end
	end

endmodule

// File: source/box_overlay.sv
`timescale 1ns/100ps

module box_overlay import track_pkg::*; (
	input  logic               cmos_pclk_gbuf,
	input  logic               rst_n,
	input  logic               i_pix_valid,
	input  logic [PIX_W-1:0]   i_pix_data,
	input  logic [COORD_W-1:0] i_col,
	input  logic [COORD_W-1:0] i_row,
	input  logic [COORD_W-1:0] i_col_min,
	input  logic [COORD_W-1:0] i_col_max,
	input  logic [COORD_W-1:0] i_row_min,
	input  logic [COORD_W-1:0] i_row_max,
	input  logic               i_box_valid,
	output logic               o_pix_valid,
	output logic [PIX_W-1:0]   o_pix_data
);

	logic col_in;
	logic row_in;
	logic on_vert;
	logic on_horz;
	logic on_border;

	assign col_in = (i_col >= i_col_min) && (i_col <= i_col_max);
	assign row_in = (i_row >= i_row_min) && (i_row <= i_row_max);

	// left/right edges, then top/bottom edges
	assign on_vert   = ((i_col == i_col_min) || (i_col == i_col_max)) && row_in;
	assign on_horz   = ((i_row == i_row_min) || (i_row == i_row_max)) && col_in;
	assign on_border = i_box_valid && (on_vert || on_horz);

	always_ff @(posedge cmos_pclk_gbuf or negedge rst_n) begin
		if (!rst_n) begin
			o_pix_valid <= 1'b0;
		end else begin
			o_pix_valid <= i_pix_valid;
		end
	end

	always_ff @(posedge cmos_pclk_gbuf) begin
		if (i_pix_valid) begin
			o_pix_data <= on_border ? BOX_PIX : i_pix_data;
		end
	end

endmodule

// File: source/track_top.sv
`timescale 1ns/100ps

module track_top import track_pkg::*; (
	input  logic               cmos_pclk_gbuf,
	input  logic               rst_n,
	input  logic               i_cam_vsync,
	input  logic               i_cam_href,
	input  logic [BYTE_W-1:0]  i_cam_d,
	input  logic               i_track_en,
	output logic               o_pix_valid,
	output logic [PIX_W-1:0]   o_pix_data,
	output logic [COORD_W-1:0] o_box_col_min,
	output logic [COORD_W-1:0] o_box_col_max,
	output logic [COORD_W-1:0] o_box_row_min,
	output logic [COORD_W-1:0] o_box_row_max,
	output logic               o_box_valid,
	output logic               o_track_done
);

	cam_raw_t           cam_dly;
	pix_out_t           pix_dly;
	logic               pk_valid;
	logic [PIX_W-1:0]   pk_data;
	logic               pk_href;
	logic               frame_start;
	logic               capture;
	logic               frame_end;
	logic [COORD_W-1:0] pos_col;
	logic [COORD_W-1:0] pos_row;

	////////////////////
	// camera side

	sig_delay #(.T(cam_raw_t), .DELAY(CAM_DELAY)) u_cam_delay (
		.cmos_pclk_gbuf (cmos_pclk_gbuf),
		.rst_n          (rst_n),
		.i_data         ({i_cam_vsync, i_cam_href, i_cam_d}),
		.o_data         (cam_dly)
	);

	pix_pack u_pix_pack (
		.cmos_pclk_gbuf (cmos_pclk_gbuf),
		.rst_n          (rst_n),
		.i_href         (cam_dly.href),
		.i_byte         (cam_dly.data),
		.o_pix_valid    (pk_valid),
		.o_pix_data     (pk_data),
		.o_href         (pk_href)
	);

	track_fsm u_track_fsm (
		.cmos_pclk_gbuf (cmos_pclk_gbuf),
		.rst_n          (rst_n),
		.i_vsync        (cam_dly.vsync),
		.i_track_en     (i_track_en),
		.o_frame_start  (frame_start),
		.o_capture      (capture),
		.o_frame_end    (frame_end)
	);

	pix_pos_cnt u_pix_pos_cnt (
		.cmos_pclk_gbuf (cmos_pclk_gbuf),
		.rst_n          (rst_n),
		.i_frame_start  (frame_start),
		.i_pix_valid    (pk_valid),
		.i_href         (pk_href),
		.o_col          (pos_col),
		.o_row          (pos_row)
	);

	// pixel held back one stage to meet its position
	sig_delay #(.T(pix_out_t), .DELAY(1)) u_pix_delay (
		.cmos_pclk_gbuf (cmos_pclk_gbuf),
		.rst_n          (rst_n),
		.i_data         ({pk_valid, pk_data}),
		.o_data         (pix_dly)
	);

	////////////////////
	// tracking and overlay

	box_track u_box_track (
		.cmos_pclk_gbuf (cmos_pclk_gbuf),
		.rst_n          (rst_n),
		.i_frame_start  (frame_start),
		.i_capture      (capture),
		.i_frame_end    (frame_end),
		.i_pix_valid    (pk_valid),
		.i_pix_data     (pk_data),
		.i_col          (pos_col),
		.i_row          (pos_row),
		.o_col_min      (o_box_col_min),
		.o_col_max      (o_box_col_max),
		.o_row_min      (o_box_row_min),
		.o_row_max      (o_box_row_max),
		.o_box_valid    (o_box_valid),
		.o_track_done   (o_track_done)
	);

	box_overlay u_box_overlay (
		.cmos_pclk_gbuf (cmos_pclk_gbuf),
		.rst_n          (rst_n),
		.i_pix_valid    (pix_dly.valid),
		.i_pix_data     (pix_dly.data),
		.i_col          (pos_col),
		.i_row          (pos_row),
		.i_col_min      (o_box_col_min),
		.i_col_max      (o_box_col_max),
		.i_row_min      (o_box_row_min),
		.i_row_max      (o_box_row_max),
		.i_box_valid    (o_box_valid),
		.o_pix_valid    (o_pix_valid),
		.o_pix_data     (o_pix_data)
	);

endmodule

// File: dv/tb_track_top.sv
`timescale 1ns/100ps

module tb_track_top import track_pkg::*; ();

	// 4 frames of about 330 cycles each, with wide margin
	localparam int MAX_CYCLES = 20000;
	localparam int ROWS       = 8;
	localparam int COLS       = 16;

	logic               cmos_pclk_gbuf;
	logic               rst_n;
	logic               i_cam_vsync;
	logic               i_cam_href;
	logic [BYTE_W-1:0]  i_cam_d;
	logic               i_track_en;
	logic               o_pix_valid;
	logic [PIX_W-1:0]   o_pix_data;
	logic [COORD_W-1:0] o_box_col_min;
	logic [COORD_W-1:0] o_box_col_max;
	logic [COORD_W-1:0] o_box_row_min;
	logic [COORD_W-1:0] o_box_row_max;
	logic               o_box_valid;
	logic               o_track_done;

	logic [BYTE_W-1:0] frame_b [ROWS][2*COLS];
	logic [PIX_W-1:0]  got_q [$];
	int                done_cnt;
	int                err_cnt;
	int                tests_run;
	int                cycle_cnt;
	int                box_cmin;
	int                box_cmax;
	int                box_rmin;
	int                box_rmax;

	track_top u_track_top (
		.cmos_pclk_gbuf (cmos_pclk_gbuf),
		.rst_n          (rst_n),
		.i_cam_vsync    (i_cam_vsync),
		.i_cam_href     (i_cam_href),
		.i_cam_d        (i_cam_d),
		.i_track_en     (i_track_en),
		.o_pix_valid    (o_pix_valid),
		.o_pix_data     (o_pix_data),
		.o_box_col_min  (o_box_col_min),
		.o_box_col_max  (o_box_col_max),
		.o_box_row_min  (o_box_row_min),
		.o_box_row_max  (o_box_row_max),
		.o_box_valid    (o_box_valid),
		.o_track_done   (o_track_done)
	);

	always #50 cmos_pclk_gbuf = ~cmos_pclk_gbuf;

	// outputs settle after the rising edge
	always @(negedge cmos_pclk_gbuf) begin
		if (o_pix_valid) got_q.push_back(o_pix_data);
		if (o_track_done) done_cnt++;
	end

	always @(posedge cmos_pclk_gbuf) begin
		cycle_cnt++;
		if (cycle_cnt >= MAX_CYCLES) begin
			$display("timeout: run did not finish within %0d cycles", MAX_CYCLES);
			$display("TEST FAIL");
			$finish;
		end
	end

	////////////////////
	// helpers

	task automatic report_mismatch(input string name, input int expv, input int actv);
		$display("Mismatch at %0t: %s expected %0h got %0h", $time, name, expv, actv);
		err_cnt++;
	endtask

	task automatic end_test(input string name, input int err_before);
		tests_run++;
		$display("%s: %s (%0d errors)", name,
			(err_cnt == err_before) ? "ok" : "failed", err_cnt - err_before);
	endtask

	function automatic bit is_border(input int c, input int r);
		bit on_vert;
		bit on_horz;
		on_vert = (c == box_cmin || c == box_cmax) && r >= box_rmin && r <= box_rmax;
		on_horz = (r == box_rmin || r == box_rmax) && c >= box_cmin && c <= box_cmax;
		return on_vert || on_horz;
	endfunction

	// luma never above the threshold
	task automatic fill_dim_frame();
		for (int r = 0; r < ROWS; r++) begin
			for (int c = 0; c < COLS; c++) begin
				frame_b[r][2*c]   = 8'($urandom_range(int'(Y_THRESH), 0));
				frame_b[r][2*c+1] = 8'($urandom);
			end
		end
	endtask

	task automatic place_bright(input int n);
		int c;
		int r;
		for (int i = 0; i < n; i++) begin
			c = int'($urandom_range(COLS - 1, 0));
			r = int'($urandom_range(ROWS - 1, 0));
			frame_b[r][2*c] = 8'($urandom_range(255, int'(Y_THRESH) + 1));
			if (i == 0 || c < box_cmin) box_cmin = c;
			if (i == 0 || c > box_cmax) box_cmax = c;
			if (i == 0 || r < box_rmin) box_rmin = r;
			if (i == 0 || r > box_rmax) box_rmax = r;
		end
	endtask

	// vsync blanking, 8 lines of 32 bytes with line blanking, vsync back high
	task automatic send_frame();
		got_q.delete();
		i_cam_vsync = 1'b1;
		i_cam_href  = 1'b0;
		repeat (6) @(negedge cmos_pclk_gbuf);
		i_cam_vsync = 1'b0;
		repeat (4) @(negedge cmos_pclk_gbuf);
		for (int r = 0; r < ROWS; r++) begin
			for (int b = 0; b < 2*COLS; b++) begin
				i_cam_href = 1'b1;
				i_cam_d    = frame_b[r][b];
				@(negedge cmos_pclk_gbuf);
			end
			i_cam_href = 1'b0;
			i_cam_d    = '0;
			repeat (6) @(negedge cmos_pclk_gbuf);
		end
		repeat (4) @(negedge cmos_pclk_gbuf);
		i_cam_vsync = 1'b1;
		repeat (12) @(negedge cmos_pclk_gbuf);
	endtask

	task automatic wait_done(input int start_cnt);
		int waited;
		waited = 0;
		while (done_cnt == start_cnt && waited < 40) begin
			@(negedge cmos_pclk_gbuf);
			waited++;
		end
		if (done_cnt == start_cnt) begin
			$display("no done pulse seen after the end of a tracked frame");
			err_cnt++;
		end else if (done_cnt != start_cnt + 1) begin
			report_mismatch("o_track_done cycles", 1, done_cnt - start_cnt);
		end
	endtask

	task automatic check_pixels(input bit box_on);
		int               n;
		logic [PIX_W-1:0] exp_pix;
		if (got_q.size() != ROWS * COLS) begin
			report_mismatch("pixel count", ROWS * COLS, got_q.size());
		end
		n = (got_q.size() < ROWS * COLS) ? got_q.size() : ROWS * COLS;
		for (int i = 0; i < n; i++) begin
			exp_pix = {frame_b[i / COLS][2*(i % COLS)], frame_b[i / COLS][2*(i % COLS)+1]};
			if (box_on && is_border(i % COLS, i / COLS)) exp_pix = BOX_PIX;
			if (got_q[i] != exp_pix) begin
				report_mismatch("o_pix_data", int'(exp_pix), int'(got_q[i]));
			end
		end
	endtask

	////////////////////
	// directed tests

	task automatic test_reset();
		int e0;
		e0 = err_cnt;
		if (o_pix_valid !== 1'b0) report_mismatch("o_pix_valid", 0, int'(o_pix_valid));
		if (o_track_done !== 1'b0) report_mismatch("o_track_done", 0, int'(o_track_done));
		if (o_box_valid !== 1'b0) report_mismatch("o_box_valid", 0, int'(o_box_valid));
		if (o_box_col_min != '0) report_mismatch("o_box_col_min", 0, int'(o_box_col_min));
		if (o_box_col_max != '0) report_mismatch("o_box_col_max", 0, int'(o_box_col_max));
		if (o_box_row_min != '0) report_mismatch("o_box_row_min", 0, int'(o_box_row_min));
		if (o_box_row_max != '0) report_mismatch("o_box_row_max", 0, int'(o_box_row_max));
		end_test("reset state", e0);
	endtask

	task automatic test_pairing();
		int e0;
		int d0;
		e0 = err_cnt;
		d0 = done_cnt;
		fill_dim_frame();
		send_frame();
		repeat (20) @(negedge cmos_pclk_gbuf);
		check_pixels(1'b0);
		if (done_cnt != d0) begin
			$display("done pulse seen while tracking was disabled");
			err_cnt++;
		end
		end_test("pixel pairing", e0);
	endtask

	task automatic test_box();
		int e0;
		int d0;
		e0 = err_cnt;
		i_track_en = 1'b1;
		fill_dim_frame();
		place_bright(4);
		d0 = done_cnt;
		send_frame();
		wait_done(d0);
		check_pixels(1'b0);
		if (o_box_valid !== 1'b1) report_mismatch("o_box_valid", 1, int'(o_box_valid));
		if (int'(o_box_col_min) != box_cmin)
			report_mismatch("o_box_col_min", box_cmin, int'(o_box_col_min));
		if (int'(o_box_col_max) != box_cmax)
			report_mismatch("o_box_col_max", box_cmax, int'(o_box_col_max));
		if (int'(o_box_row_min) != box_rmin)
			report_mismatch("o_box_row_min", box_rmin, int'(o_box_row_min));
		if (int'(o_box_row_max) != box_rmax)
			report_mismatch("o_box_row_max", box_rmax, int'(o_box_row_max));
		end_test("bounding box", e0);
	endtask

	// box from the previous frame is drawn on this one
	task automatic test_overlay();
		int e0;
		int d0;
		e0 = err_cnt;
		fill_dim_frame();
		d0 = done_cnt;
		send_frame();
		wait_done(d0);
		check_pixels(1'b1);
		if (o_box_valid !== 1'b0) report_mismatch("o_box_valid", 0, int'(o_box_valid));
		end_test("overlay", e0);
	endtask

	task automatic test_disable();
		int e0;
		int d0;
		e0 = err_cnt;
		i_track_en = 1'b0;
		fill_dim_frame();
		d0 = done_cnt;
		send_frame();
		repeat (20) @(negedge cmos_pclk_gbuf);
		check_pixels(1'b0);
		if (done_cnt != d0) begin
			$display("done pulse seen after tracking was disabled");
			err_cnt++;
		end
		end_test("disable", e0);
	endtask

	initial begin
		cmos_pclk_gbuf = 1'b0;
		rst_n          = 1'b0;
		i_cam_vsync    = 1'b1;
		i_cam_href     = 1'b0;
		i_cam_d        = '0;
		i_track_en     = 1'b0;
		done_cnt       = 0;
		err_cnt        = 0;
		tests_run      = 0;
		cycle_cnt      = 0;
		void'($urandom(32'h98665aa0));
		repeat (3) @(posedge cmos_pclk_gbuf);
		@(negedge cmos_pclk_gbuf);
		rst_n = 1'b1;
		@(negedge cmos_pclk_gbuf);
		test_reset();
		test_pairing();
		test_box();
		test_overlay();
		test_disable();
		$display("tests run: %0d, errors: %0d", tests_run, err_cnt);
		if (err_cnt == 0) begin
			$display("TEST PASS");
		end else begin
			$display("TEST FAIL");
		end
		$finish;
	end

endmodule

// File: compile.f
common/track_pkg.sv
source/sig_delay.sv
source/pix_pack.sv
tracker/track_fsm.sv
tracker/pix_pos_cnt.sv
tracker/box_track.sv
source/box_overlay.sv
source/track_top.sv
dv/tb_track_top.sv

// File: run_sim.sh
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

verilator --binary --timing -f compile.f --top-module tb_track_top -o tb_sim

sim_out=$(./obj_dir/tb_sim)
echo "$sim_out"

if grep -qx "TEST PASS" <<< "$sim_out"; then
	exit 0
else
	exit 1
fi
